/* hw/acc_cpu.sv */
`timescale 1ns/100ps

module acc_cpu
   import bus_pkg::*;
   import cpu_pkg::*;
(
   input logic     clk,
   input logic     rst_n,
   cpu_bus_if.cpu  bus
);

   cpu_state_t state;
   cpu_state_t nxt_state;
   addr_t      pc;
   addr_t      nxt_pc;
   data_t      acc;
   data_t      nxt_acc;
   opcode_t    opcode;
   opcode_t    nxt_opcode;

   // Next state, evaluated every cycle but only taken when clken is high
   always_comb
   begin
      nxt_state   = state;
      nxt_pc      = pc;
      nxt_acc     = acc;
      nxt_opcode  = opcode;

      case (state)
         FETCH_OP:
         begin
            // No fetch is on the bus yet in the first cycle after reset
            if (bus.vpa)
            begin
               nxt_opcode = opcode_t'(bus.rdata[OPC_MSB:OPC_LSB]);
               nxt_pc     = pc + 16'd1;
               if (nxt_opcode == HALT)
                  nxt_state = STOP;
               else
                  nxt_state = FETCH_ARG;
            end
         end

         FETCH_ARG:
         begin
            nxt_pc      = pc + 16'd1;
            nxt_state   = FETCH_OP;
            case (opcode)
               LDI:
                  nxt_acc = bus.rdata;
               JZ:
               begin
                  if (acc == '0)
                     nxt_pc = bus.rdata;
               end
               JMP:
                  nxt_pc = bus.rdata;
               // Memory operand, one more bus cycle
               default:
                  nxt_state = EXEC;
            endcase
         end

         EXEC:
         begin
            nxt_state = FETCH_OP;
            case (opcode)
               LD:
                  nxt_acc = bus.rdata;
               ADD:
                  nxt_acc = acc + bus.rdata;
               XOR:
                  nxt_acc = acc ^ bus.rdata;
               AND:
                  nxt_acc = acc & bus.rdata;
               // ST only drives the bus
               default:
                  nxt_acc = acc;
            endcase
         end

         // STOP holds until reset
         default:
            nxt_state = state;
      endcase
   end

   // Control state and bus strobes
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         state       <= FETCH_OP;
         pc          <= RESET_VECTOR;
         bus.address <= RESET_VECTOR;
         bus.rnw     <= 1'b1;
         bus.vpa     <= 1'b0;
         bus.vda     <= 1'b0;
      end
      else if (bus.clken)
      begin
         state <= nxt_state;
         pc    <= nxt_pc;
         // Set up the access for the state being entered
         // EXEC is only entered from FETCH_ARG, whose operand word is on rdata
         if (nxt_state == EXEC)
            bus.address <= bus.rdata;
         else
            bus.address <= nxt_pc;
         bus.rnw <= !((nxt_state == EXEC) && (nxt_opcode == ST));
         bus.vpa <= (nxt_state == FETCH_OP) || (nxt_state == FETCH_ARG);
         bus.vda <= (nxt_state == EXEC);
      end
   end

   // Datapath registers
   always_ff @(posedge clk)
   begin
      if (bus.clken)
      begin
         acc       <= nxt_acc;
         opcode    <= nxt_opcode;
         bus.wdata <= nxt_acc;
      end
   end

endmodule

/* hw/block_ram.sv */
`timescale 1ns/100ps

module block_ram
   import bus_pkg::*;
#(
   parameter int RAM_ADDR_BITS = 12
)
(
   input  logic                     clk,
   input  logic [RAM_ADDR_BITS-1:0] address,
   input  data_t                    wdata,
   input  logic                     we,
   output data_t                    rdata
);

   localparam int DEPTH = 2 ** RAM_ADDR_BITS;

   data_t mem [DEPTH];

   // Firmware image, opcode and operand words in address order
   initial
   begin
      $readmemh("hw/firmware.hex", mem);
   end

   // Read every cycle, data valid one clock after the address
   always_ff @(posedge clk)
   begin
      if (we)
         mem[address] <= wdata;
      rdata <= mem[address];
   end

endmodule

/* hw/bus_pkg.sv */
package bus_pkg;

   // Width of the CPU address bus
   localparam int ADDR_BITS = 16;

   // Width of a data word, RAM and CPU alike
   localparam int DATA_BITS = 16;

   typedef logic [ADDR_BITS-1:0] addr_t;
   typedef logic [DATA_BITS-1:0] data_t;

   // System address map
   //   0000 - RAM, bottom copy
   //   fe08 - UART status (bit 1 tx_busy, bit 0 rx_valid)
   //   fe09 - UART data
   //   top  - RAM mirror where the firmware keeps its variables

   // UART occupies two words, status then data
   localparam addr_t UART_BASE = 16'hfe08;

   // First fetch address after reset
   localparam addr_t RESET_VECTOR = 16'h0000;

endpackage

/* hw/cpu_bus_if.sv */
`timescale 1ns/100ps

interface cpu_bus_if
   import bus_pkg::*;
(
   input logic clk
);

   addr_t address;
   data_t wdata;
   data_t rdata;
   logic  rnw;
   // Opcode or operand fetch
   logic  vpa;
   // Data access
   logic  vda;
   // Low stretches the current access
   logic  clken;

   modport cpu (
      input  clk,
      output address, wdata, rnw, vpa, vda,
      input  rdata, clken
   );

   modport system (
      input  clk,
      input  address, wdata, rnw, vpa, vda,
      output rdata, clken
   );

endinterface

/* hw/cpu_pkg.sv */
package cpu_pkg;

   // Instruction format
   //   word 0: opcode in bits 15:12, the rest unused
   //   word 1: operand, an immediate value or an address
   localparam int OPC_MSB = 15;
   localparam int OPC_LSB = OPC_MSB - 3;

   // Blank memory reads as HALT
   typedef enum logic [3:0] {
      HALT = 4'h0,
      LDI  = 4'h1,
      LD   = 4'h2,
      ST   = 4'h3,
      ADD  = 4'h4,
      XOR  = 4'h5,
      AND  = 4'h6,
      JZ   = 4'h7,
      JMP  = 4'h8
   } opcode_t;

   // FETCH_OP and FETCH_ARG are vpa cycles, EXEC is a vda cycle
   typedef enum logic [1:0] {
      FETCH_OP,
      FETCH_ARG,
      EXEC,
      STOP
   } cpu_state_t;

endpackage

/* hw/firmware.hex */
// Echo and checksum firmware, one instruction per line
// Columns: opcode word, operand word, then the word address and mnemonic
1000 0000 // 00 LDI 0
3000 ff00 // 02 ST  sum
2000 fe08 // 04 LD  uart status, wait for rx_valid
6000 0040 // 06 AND k_rx_valid
7000 0004 // 08 JZ  04
2000 fe09 // 0a LD  uart data
3000 ff01 // 0c ST  char
5000 0042 // 0e XOR k_cr
7000 0020 // 10 JZ  20, carriage return
2000 ff00 // 12 LD  sum
4000 ff01 // 14 ADD char
3000 ff00 // 16 ST  sum
2000 ff01 // 18 LD  char
5000 0043 // 1a XOR k_case
3000 ff02 // 1c ST  reply
8000 0028 // 1e JMP 28
2000 ff00 // 20 LD  sum
3000 ff02 // 22 ST  reply
1000 0000 // 24 LDI 0
3000 ff00 // 26 ST  sum
2000 fe08 // 28 LD  uart status, wait for tx_busy low
6000 0041 // 2a AND k_tx_busy
7000 0030 // 2c JZ  30
8000 0028 // 2e JMP 28
2000 ff02 // 30 LD  reply
3000 fe09 // 32 ST  uart data
8000 0004 // 34 JMP 04
// Constants k_rx_valid, k_tx_busy, k_cr, k_case
@40
0001 0002 000d 0020

/* hw/system.sv */
`timescale 1ns/100ps

module system
   import bus_pkg::*;
#(
   parameter int CLKSPEED      = 50_000_000,
   parameter int BAUD          = 115_200,
   parameter int RAM_ADDR_BITS = 12
)
(
   input  logic clk,
   input  logic rst_n,
   input  logic rxd,
   output logic txd,
   output logic led_rx,
   output logic led_tx
);

   // Rounded to the nearest clock
   localparam int CLKS_PER_BIT = (CLKSPEED + BAUD / 2) / BAUD;

   logic  rst_core_n;
   logic  clken_q;
   logic  uart_cs;
   logic  ram_cs;
   logic  ram_we;
   logic  uart_we;
   logic  uart_rd;
   data_t ram_rdata;
   data_t uart_rdata;

   cpu_bus_if bus_if (.clk(clk));

   always_ff @(posedge clk)
   begin
      rst_core_n <= rst_n;
   end

   always_ff @(posedge clk)
   begin
      if (!rst_core_n)
         clken_q <= 1'b1;
      else
         clken_q <= bus_if.clken;
   end

   // High in reset; every vpa or vda access is held for a second clock
   assign bus_if.clken = !rst_core_n || !clken_q || !(bus_if.vpa || bus_if.vda);

   assign uart_cs = ({bus_if.address[ADDR_BITS-1:1], 1'b0} == UART_BASE);

   // RAM mirrored at the bottom and top of the address space
   assign ram_cs = (~|bus_if.address[ADDR_BITS-1:RAM_ADDR_BITS]) ||
                   (&bus_if.address[ADDR_BITS-1:RAM_ADDR_BITS]);

   // UART takes priority over the top RAM mirror
   // The firmware image stays untouched while the core is held in reset
   assign ram_we  = ram_cs && !uart_cs && !bus_if.rnw && bus_if.clken && rst_core_n;
   assign uart_we = uart_cs && !bus_if.rnw && bus_if.clken;
   assign uart_rd = bus_if.rnw && bus_if.clken;

   always_comb
   begin
      if (uart_cs)
         bus_if.rdata = uart_rdata;
      else if (ram_cs)
         bus_if.rdata = ram_rdata;
      else
         bus_if.rdata = '0;
   end

   assign led_rx = !rxd;
   assign led_tx = !txd;

   acc_cpu cpu_inst (
      .clk   (clk),
      .rst_n (rst_core_n),
      .bus   (bus_if.cpu)
   );

   block_ram #(
      .RAM_ADDR_BITS (RAM_ADDR_BITS)
   ) ram_inst (
      .clk     (clk),
      .address (bus_if.address[RAM_ADDR_BITS-1:0]),
      .wdata   (bus_if.wdata),
      .we      (ram_we),
      .rdata   (ram_rdata)
   );

   uart #(
      .CLKS_PER_BIT (CLKS_PER_BIT)
   ) uart_inst (
      .clk       (clk),
      .rst_n     (rst_core_n),
      .reg_sel   (bus_if.address[0]),
      .wdata     (bus_if.wdata),
      .cs        (uart_cs),
      .we        (uart_we),
      .rd_strobe (uart_rd),
      .rdata     (uart_rdata),
      .rxd       (rxd),
      .txd       (txd)
   );

endmodule

/* hw/uart.sv */
`timescale 1ns/100ps

module uart
   import bus_pkg::*;
#(
   parameter int CLKS_PER_BIT = 16
)
(
   input  logic  clk,
   input  logic  rst_n,
   input  logic  reg_sel,
   input  data_t wdata,
   input  logic  cs,
   input  logic  we,
   input  logic  rd_strobe,
   output data_t rdata,
   input  logic  rxd,
   output logic  txd
);

   localparam int CNT_BITS = $clog2(CLKS_PER_BIT + 1);
   localparam logic [CNT_BITS-1:0] BIT_LAST  = CNT_BITS'(CLKS_PER_BIT - 1);
   localparam logic [CNT_BITS-1:0] HALF_LAST = CNT_BITS'(CLKS_PER_BIT / 2 - 1);

   logic                rx_meta;
   logic                rx_sync;
   logic                rx_busy;
   logic [CNT_BITS-1:0] rx_cnt;
   logic [3:0]          rx_bit;
   logic [7:0]          rx_shift;
   logic [7:0]          rx_data;
   logic                rx_valid;
   logic                tx_busy;
   logic [CNT_BITS-1:0] tx_cnt;
   logic [3:0]          tx_bit;
   logic [9:0]          tx_shift;
   logic                data_rd;
   logic                data_wr;

   assign data_rd = cs && rd_strobe && reg_sel;
   assign data_wr = we && reg_sel;

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         rx_meta <= 1'b1;
         rx_sync <= 1'b1;
      end
      else
      begin
         rx_meta <= rxd;
         rx_sync <= rx_meta;
      end
   end

   // Receiver, rx_bit 0 is the start bit and 9 the stop bit
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         rx_busy  <= 1'b0;
         rx_valid <= 1'b0;
         rx_cnt   <= '0;
         rx_bit   <= '0;
      end
      else
      begin
         if (data_rd)
            rx_valid <= 1'b0;
         if (!rx_busy)
         begin
            // Count half a bit to land in the middle of the start bit
            rx_cnt <= HALF_LAST;
            rx_bit <= '0;
            if (!rx_sync)
               rx_busy <= 1'b1;
         end
         else if (rx_cnt == '0)
         begin
            rx_cnt <= BIT_LAST;
            rx_bit <= rx_bit + 4'd1;
            // Start bit gone high again is a glitch
            if ((rx_bit == 4'd0) && rx_sync)
               rx_busy <= 1'b0;
            if (rx_bit == 4'd9)
            begin
               rx_busy <= 1'b0;
               if (rx_sync)
                  rx_valid <= 1'b1;
            end
         end
         else
            rx_cnt <= rx_cnt - 1'b1;
      end
   end

   // LSB first, so shift in from the top
   always_ff @(posedge clk)
   begin
      if (rx_busy && (rx_cnt == '0))
      begin
         if ((rx_bit != 4'd0) && (rx_bit != 4'd9))
            rx_shift <= {rx_sync, rx_shift[7:1]};
         if ((rx_bit == 4'd9) && rx_sync)
            rx_data <= rx_shift;
      end
   end

   // Transmitter
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         tx_busy <= 1'b0;
         tx_cnt  <= '0;
         tx_bit  <= '0;
      end
      else if (!tx_busy)
      begin
         if (data_wr)
         begin
            tx_busy <= 1'b1;
            tx_cnt  <= BIT_LAST;
            tx_bit  <= '0;
         end
      end
      else if (tx_cnt == '0)
      begin
         tx_cnt <= BIT_LAST;
         if (tx_bit == 4'd9)
            tx_busy <= 1'b0;
         else
            tx_bit <= tx_bit + 4'd1;
      end
      else
         tx_cnt <= tx_cnt - 1'b1;
   end

   // Stop, data and start bit, start bit goes out first
   always_ff @(posedge clk)
   begin
      if (!tx_busy && data_wr)
         tx_shift <= {1'b1, wdata[7:0], 1'b0};
      else if (tx_busy && (tx_cnt == '0))
         tx_shift <= {1'b1, tx_shift[9:1]};
   end

   assign txd = tx_busy ? tx_shift[0] : 1'b1;

   assign rdata = reg_sel ? {{(DATA_BITS - 8){1'b0}}, rx_data}
                          : {{(DATA_BITS - 2){1'b0}}, tx_busy, rx_valid};

endmodule

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal --top-module system_tb -f src.f \
   || { echo "Verilator build failed"; exit 1; }
./obj_dir/Vsystem_tb > sim.log 2>&1
cat sim.log
grep -q "Test failed" sim.log && { echo "Simulation FAILED"; exit 1; }
grep -q "Test completed successfully" sim.log \
   || { echo "Simulation ended without a result"; exit 1; }
echo "Simulation PASSED"

/* src.f */
hw/bus_pkg.sv
hw/cpu_pkg.sv
hw/cpu_bus_if.sv
hw/acc_cpu.sv
hw/block_ram.sv
hw/uart.sv
hw/system.sv
verif/system_tb.sv

/* verif/system_tb.sv */
`timescale 1ns/100ps

module system_tb;

   localparam int CLKSPEED     = 10_000_000;
   localparam int BAUD         = 625_000;
   localparam int CLKS_PER_BIT = CLKSPEED / BAUD;
   localparam int CLK_PERIOD   = 100;
   localparam int RESET_CYCLES = 16;
   localparam int NUM_FIXED    = 6;
   localparam int NUM_RANDOM   = 8;
   localparam int NUM_ROWS     = NUM_FIXED + NUM_RANDOM + 1;
   // Two frames per row plus firmware slack
   localparam int WATCHDOG_NS  = NUM_ROWS * (2 * 10 * CLKS_PER_BIT + 2000) * CLK_PERIOD;
   localparam logic [7:0] CR          = 8'h0d;
   localparam logic [31:0] LFSR_SEED  = 32'hfe86_e034;
   // Maximal length 32-bit Galois taps
   localparam logic [31:0] LFSR_TAPS  = 32'h8020_0003;

   logic        clk;
   logic        rst_n;
   logic        rxd;
   logic        txd;
   logic        led_rx;
   logic        led_tx;
   logic [31:0] lfsr;
   logic [7:0]  got;
   logic [7:0]  rand_byte;

   string      row_name  [NUM_ROWS];
   logic [7:0] row_byte  [NUM_ROWS];
   logic [7:0] row_reply [NUM_ROWS];

   system #(
      .CLKSPEED      (CLKSPEED),
      .BAUD          (BAUD),
      .RAM_ADDR_BITS (12)
   ) system_inst (
      .clk    (clk),
      .rst_n  (rst_n),
      .rxd    (rxd),
      .txd    (txd),
      .led_rx (led_rx),
      .led_tx (led_tx)
   );

   always
   begin
      #(CLK_PERIOD / 2) clk = ~clk;
   end

   task automatic stop_with_failure(input string reason);
      $display("%s", reason);
      $display("Test failed");
      $fatal(1);
   endtask

   task automatic check_byte(input string name, input logic [7:0] expected,
                             input logic [7:0] actual);
      if (actual !== expected)
         stop_with_failure($sformatf("mismatch in %s: expected 8'h%h, actual 8'h%h",
                                     name, expected, actual));
   endtask

   task automatic check_line(input string name, input logic expected, input logic actual);
      if (actual !== expected)
         stop_with_failure($sformatf("mismatch in %s: expected %b, actual %b",
                                     name, expected, actual));
   endtask

   function automatic logic [31:0] lfsr_next(input logic [31:0] state);
      if (state[0])
         return (state >> 1) ^ LFSR_TAPS;
      else
         return state >> 1;
   endfunction

   // One step per bit taken, a carriage return is drawn again
   task automatic draw_byte(output logic [7:0] value);
      value = CR;
      while (value == CR)
      begin
         for (int i = 0; i < 8; i++)
         begin
            value = {lfsr[0], value[7:1]};
            lfsr  = lfsr_next(lfsr);
         end
      end
   endtask

   task automatic set_row(input int index, input string name, input logic [7:0] value);
      row_name[index] = name;
      row_byte[index] = value;
   endtask

   task automatic build_table();
      logic [7:0] sum;
      set_row(0, "upper_a", 8'h41);
      set_row(1, "lower_z", 8'h7a);
      set_row(2, "digit_7", 8'h37);
      set_row(3, "tilde", 8'h7e);
      set_row(4, "cr_sum", CR);
      set_row(5, "cr_zero", CR);
      for (int i = 0; i < NUM_RANDOM; i++)
      begin
         draw_byte(rand_byte);
         set_row(NUM_FIXED + i, $sformatf("lfsr_%0d", i), rand_byte);
      end
      set_row(NUM_ROWS - 1, "cr_after_lfsr", CR);
      // Echo with bit 5 flipped, a carriage return answers with the byte sum
      sum = 8'h00;
      for (int i = 0; i < NUM_ROWS; i++)
      begin
         if (row_byte[i] == CR)
         begin
            row_reply[i] = sum;
            sum = 8'h00;
         end
         else
         begin
            row_reply[i] = row_byte[i] ^ 8'h20;
            sum = sum + row_byte[i];
         end
      end
   endtask

   // Start bit, eight data bits LSB first, stop bit
   task automatic send_byte(input string name, input logic [7:0] value);
      logic [9:0] frame;
      frame = {1'b1, value, 1'b0};
      for (int i = 0; i < 10; i++)
      begin
         rxd = frame[i];
         #1;
         check_line({name, " led_rx"}, ~frame[i], led_rx);
         repeat (CLKS_PER_BIT) @(posedge clk);
         #1;
      end
   endtask

   // Samples txd on falling clock edges near the middle of each bit
   task automatic receive_byte(input string name, output logic [7:0] value);
      @(negedge clk);
      while (txd !== 1'b0)
         @(negedge clk);
      repeat (CLKS_PER_BIT / 2) @(negedge clk);
      if (txd !== 1'b0)
         stop_with_failure($sformatf("%s: start bit on txd ended early", name));
      check_line({name, " led_tx"}, 1'b1, led_tx);
      for (int i = 0; i < 8; i++)
      begin
         repeat (CLKS_PER_BIT) @(negedge clk);
         value[i] = txd;
      end
      repeat (CLKS_PER_BIT) @(negedge clk);
      if (txd !== 1'b1)
         stop_with_failure($sformatf("%s: stop bit on txd is low", name));
   endtask

   initial
   begin
      clk   = 1'b0;
      rst_n = 1'b0;
      rxd   = 1'b1;
      lfsr  = LFSR_SEED;
      build_table();
      repeat (RESET_CYCLES) @(posedge clk);
      #1;
      rst_n = 1'b1;
      // Nothing goes out before the first byte arrives
      repeat (4 * CLKS_PER_BIT)
      begin
         @(negedge clk);
         check_line("idle txd", 1'b1, txd);
         check_line("idle led_tx", 1'b0, led_tx);
         check_line("idle led_rx", 1'b0, led_rx);
      end
      // One byte in, then its reply out, since the UART has no back-pressure
      for (int i = 0; i < NUM_ROWS; i++)
      begin
         @(posedge clk);
         #1;
         send_byte(row_name[i], row_byte[i]);
         receive_byte(row_name[i], got);
         check_byte(row_name[i], row_reply[i], got);
      end
      $display("Test completed successfully");
      $finish;
   end

   // Watchdog
   initial
   begin
      #(WATCHDOG_NS);
      stop_with_failure($sformatf("timeout: no complete reply after %0d ns", WATCHDOG_NS));
   end

endmodule
